// ==== Makefile ====
TOP = tb_host_ring

.PHONY: all build lint clean

all: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== sim.f ====
verilog/host_ring_pkg.sv
verilog/line_fifo.sv
verilog/ring_writer.sv
verilog/status_writer.sv
verilog/write_arbiter.sv
verilog/host_ring_top.sv
test/host_ring_properties.sv
test/host_ring_checker.sv
test/tb_host_ring.sv

// ==== test/host_ring_checker.sv ====
// Scoreboard for the host ring writer
// Predicts line, fence and status writes and counts the errors it finds
`timescale 1ns/1ps

module host_ring_checker
(
    input  logic clk,
    input  logic reset_n,
    input  logic [host_ring_pkg::ADDR_BITS-1:0] ring_base,
    input  logic [host_ring_pkg::ADDR_BITS-1:0] status_addr,
    input  logic [host_ring_pkg::RING_IDX_BITS-1:0] host_oldest_idx,
    input  logic in_valid,
    input  logic [host_ring_pkg::LINE_BITS-1:0] in_data,
    input  logic in_credit,
    input  logic mem_valid,
    input  host_ring_pkg::req_hdr_u mem_hdr,
    input  logic [host_ring_pkg::LINE_BITS-1:0] mem_data,
    input  logic mem_credit,
    output int err_count,
    output int lines_written,
    output int accepted_count,
    output int credit_count,
    output int outstanding,
    output logic [host_ring_pkg::RING_IDX_BITS-1:0] status_value,
    output logic status_pending
);

    // Lines accepted from the producer and not yet seen on the host channel
    logic [host_ring_pkg::LINE_BITS-1:0] line_q [$];

    logic [host_ring_pkg::RING_IDX_BITS-1:0] line_idx;
    logic [host_ring_pkg::RING_IDX_BITS-1:0] fence_tag;
    logic [host_ring_pkg::RING_IDX_BITS-1:0] oldest_q;
    int in_credits;

    // ====================
    // Prediction
    // ====================
    always @(posedge clk)
    begin
        logic [host_ring_pkg::LINE_BITS-1:0] exp_data;
        logic [host_ring_pkg::ADDR_BITS-1:0] exp_addr;
        logic [host_ring_pkg::LINE_BITS-1:0] exp_status;
        logic [host_ring_pkg::RING_IDX_BITS-1:0] next_idx;

        if (!reset_n)
        begin
            line_q.delete();
            line_idx = '0;
            fence_tag = '0;
            oldest_q = '0;
            in_credits = host_ring_pkg::IN_CREDITS;
            err_count = 0;
            lines_written = 0;
            accepted_count = 0;
            credit_count = 0;
            outstanding = 0;
            status_value = '0;
            status_pending = 1'b0;
        end
        else
        begin
            // Producer side credit accounting
            if (in_credit)
            begin
                in_credits++;
                credit_count++;
                if (in_credits > host_ring_pkg::IN_CREDITS)
                begin
                    $display("in_credit returned a credit for a line never accepted");
                    err_count++;
                end
            end
            if (in_valid)
            begin
                if (in_credits == 0)
                begin
                    $display("producer pushed a line with no input credit left");
                    err_count++;
                end
                in_credits--;
                accepted_count++;
                line_q.push_back(in_data);
            end

            // Host writes still waiting for their credit
            if (mem_credit)
            begin
                outstanding--;
            end
            if (mem_valid)
            begin
                outstanding++;
            end
            if (outstanding > host_ring_pkg::MEM_CREDITS || outstanding < 0)
            begin
                $display("[FAIL] outstanding: got %h limit %h", outstanding,
                         host_ring_pkg::MEM_CREDITS);
                err_count++;
            end

            if (mem_valid)
            begin
                case (mem_hdr.wr.kind)
                    host_ring_pkg::KIND_LINE:
                    begin
                        exp_data = '0;
                        if (line_q.size() == 0)
                        begin
                            $display("line write seen with no accepted line pending");
                            err_count++;
                        end
                        else
                        begin
                            exp_data = line_q.pop_front();
                        end
                        exp_addr = ring_base + {{host_ring_pkg::FENCE_PAD_BITS{1'b0}}, line_idx};
                        if (mem_hdr.wr.addr != exp_addr)
                        begin
                            $display("[FAIL] mem_hdr.wr.addr: got %h expected %h",
                                     mem_hdr.wr.addr, exp_addr);
                            err_count++;
                        end
                        if (mem_data != exp_data)
                        begin
                            $display("[FAIL] mem_data: got %h expected %h", mem_data, exp_data);
                            err_count++;
                        end
                        // Quarter bit must match the last fence, or a fence was skipped
                        if (line_idx[4] != fence_tag[4])
                        begin
                            $display("line at slot %0d crossed a quarter with no fence",
                                     line_idx);
                            err_count++;
                        end
                        next_idx = line_idx + 6'd1;
                        if (next_idx == oldest_q)
                        begin
                            $display("line at slot %0d ran into the host oldest index",
                                     line_idx);
                            err_count++;
                        end
                        line_idx = next_idx;
                        lines_written++;
                    end

                    host_ring_pkg::KIND_FENCE:
                    begin
                        // The tag commits every line written so far
                        if (mem_hdr.fence.tag != line_idx)
                        begin
                            $display("[FAIL] mem_hdr.fence.tag: got %h expected %h",
                                     mem_hdr.fence.tag, line_idx);
                            err_count++;
                        end
                        if (mem_hdr.fence.pad != '0)
                        begin
                            $display("[FAIL] mem_hdr.fence.pad: got %h expected %h",
                                     mem_hdr.fence.pad, {host_ring_pkg::FENCE_PAD_BITS{1'b0}});
                            err_count++;
                        end
                        // A fence carries no payload
                        if (mem_data != '0)
                        begin
                            $display("[FAIL] mem_data: got %h expected %h", mem_data,
                                     {host_ring_pkg::LINE_BITS{1'b0}});
                            err_count++;
                        end
                        fence_tag = line_idx;
                        status_pending = 1'b1;
                    end

                    host_ring_pkg::KIND_STATUS:
                    begin
                        if (!status_pending)
                        begin
                            $display("status write seen with no fence before it");
                            err_count++;
                        end
                        if (mem_hdr.wr.addr != status_addr)
                        begin
                            $display("[FAIL] mem_hdr.wr.addr: got %h expected %h",
                                     mem_hdr.wr.addr, status_addr);
                            err_count++;
                        end
                        exp_status = {{(host_ring_pkg::LINE_BITS
                                        - host_ring_pkg::RING_IDX_BITS){1'b0}}, fence_tag};
                        if (mem_data != exp_status)
                        begin
                            $display("[FAIL] mem_data: got %h expected %h", mem_data, exp_status);
                            err_count++;
                        end
                        status_value = mem_data[host_ring_pkg::RING_IDX_BITS-1:0];
                        status_pending = 1'b0;
                    end

                    default:
                    begin
                        $display("host write with an unknown kind %0d", mem_hdr.wr.kind);
                        err_count++;
                    end
                endcase
            end

            // Oldest index as it stood when this cycle's grants were made
            oldest_q = host_oldest_idx;
        end
    end

endmodule

// ==== test/host_ring_properties.sv ====
// Concurrent assertions on the write arbiter
// Write credit limits, round-robin order and status request hold
`timescale 1ns/1ps

module host_ring_properties
(
    input  logic clk,
    input  logic reset_n,
    input  logic ring_grant,
    input  logic stat_req,
    input  logic stat_grant,
    input  logic mem_credit,
    input  logic [host_ring_pkg::MEM_CNT_BITS-1:0] credits
);

    // The count stays between zero and its starting value
    // A wrap below zero shows up as a count above the limit
    assert property (@(posedge clk) disable iff (!reset_n)
        credits <= host_ring_pkg::MEM_CREDIT_INIT)
        else $error("host write credit count left its range");

    // A status write passed over once wins the next grant
    assert property (@(posedge clk) disable iff (!reset_n)
        (ring_grant && stat_req) |=> !ring_grant)
        else $error("ring writer granted twice while a status write waited");

    // Returned credits never push the count past its starting value
    assert property (@(posedge clk) disable iff (!reset_n)
        mem_credit |-> (credits < host_ring_pkg::MEM_CREDIT_INIT))
        else $error("host returned a write credit that was never spent");

    // A waiting status write stays up until it is granted
    assert property (@(posedge clk) disable iff (!reset_n)
        (stat_req && !stat_grant) |=> stat_req)
        else $error("status request dropped before its grant");

endmodule

// ==== test/tb_host_ring.sv ====
// Testbench for the host ring-buffer writer
// Clock, reset, LFSR, stimulus table, host memory credit model, result line
`timescale 1ns/1ps

module tb_host_ring;

    logic clk = 1'b0;
    logic reset_n;
    logic enable;
    logic [host_ring_pkg::ADDR_BITS-1:0] ring_base;
    logic [host_ring_pkg::ADDR_BITS-1:0] status_addr;
    logic [host_ring_pkg::RING_IDX_BITS-1:0] host_oldest_idx;
    logic in_valid;
    logic [host_ring_pkg::LINE_BITS-1:0] in_data;
    logic in_credit;
    logic mem_valid;
    host_ring_pkg::req_hdr_u mem_hdr;
    logic [host_ring_pkg::LINE_BITS-1:0] mem_data;
    logic mem_credit = 1'b0;

    int chk_errors;
    int lines_written;
    int accepted_count;
    int credit_count;
    int outstanding;
    logic [host_ring_pkg::RING_IDX_BITS-1:0] status_value;
    logic status_pending;

    // ====================
    // Stimulus table
    // ====================
    // Burst length, idle gap, oldest index, oldest index after a stall, credits withheld
    localparam int ROWS = 6;
    int row_burst [ROWS] = '{5, 20, 12, 10, 24, 16};
    int row_gap [ROWS] = '{30, 30, 40, 30, 30, 30};
    logic [5:0] row_oldest [ROWS] = '{6'd0, 6'd0, 6'd0, 6'd40, 6'd20, 6'd30};
    logic [5:0] row_release [ROWS] = '{6'd0, 6'd0, 6'd0, 6'd8, 6'd20, 6'd30};
    logic row_withhold [ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};

    int tb_errors = 0;
    int lines_sent = 0;
    int credit_returns = 0;
    logic withhold = 1'b0;
    logic withhold_q = 1'b0;
    logic hold_active = 1'b0;
    logic [5:0] release_idx;
    logic [31:0] data_lfsr = 32'hc66e;
    logic [31:0] mem_lfsr = 32'hc66e;

    host_ring_top i_dut
    (
        .clk,
        .reset_n,
        .enable,
        .ring_base,
        .status_addr,
        .host_oldest_idx,
        .in_valid,
        .in_data,
        .in_credit,
        .mem_valid,
        .mem_hdr,
        .mem_data,
        .mem_credit
    );

    host_ring_checker i_checker
    (
        .clk,
        .reset_n,
        .ring_base,
        .status_addr,
        .host_oldest_idx,
        .in_valid,
        .in_data,
        .in_credit,
        .mem_valid,
        .mem_hdr,
        .mem_data,
        .mem_credit,
        .err_count(chk_errors),
        .lines_written,
        .accepted_count,
        .credit_count,
        .outstanding,
        .status_value,
        .status_pending
    );

    bind write_arbiter host_ring_properties i_properties
    (
        .clk(clk),
        .reset_n(reset_n),
        .ring_grant(ring_grant),
        .stat_req(stat_req),
        .stat_grant(stat_grant),
        .mem_credit(mem_credit),
        .credits(credits)
    );

    always #10 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(inout logic [31:0] s, input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            s = lfsr_step(s);
            v = {v[30:0], s[0]};
        end
    endtask

    // ====================
    // Host memory credit model
    // ====================
    int due [8] = '{default: 0};
    int backlog = 0;
    logic [2:0] cyc = '0;

    always @(posedge clk)
    begin
        withhold_q <= withhold;
        if (reset_n && in_credit)
        begin
            credit_returns++;
        end
    end

    // Each write returns its credit 1 to 4 cycles later unless credits are withheld
    always @(negedge clk)
    begin
        logic [31:0] rnd;
        logic [2:0] delay;

        backlog += due[cyc];
        due[cyc] = 0;
        if (reset_n && mem_valid)
        begin
            draw_bits(mem_lfsr, 2, rnd);
            delay = {1'b0, rnd[1:0]} + 3'd1;
            due[cyc + delay]++;
        end
        mem_credit = !withhold_q && backlog > 0;
        if (mem_credit)
        begin
            backlog--;
        end
        cyc = cyc + 3'd1;
    end

    function automatic int credits_left();
        return host_ring_pkg::IN_CREDITS + credit_returns - lines_sent;
    endfunction

    task automatic wait_credit(input int limit, output logic ok);
        int t;
        t = 0;
        while (credits_left() == 0 && t < limit)
        begin
            @(negedge clk);
            t++;
        end
        ok = credits_left() != 0;
    endtask

    // In a hold row the producer is expected to stall before the hold is released
    task automatic send_line();
        logic ok;
        logic [31:0] rnd;
        wait_credit(hold_active ? 40 : 300, ok);
        if (!ok && hold_active)
        begin
            if (withhold && outstanding != host_ring_pkg::MEM_CREDITS)
            begin
                $display("[FAIL] outstanding: got %h expected %h", outstanding,
                         host_ring_pkg::MEM_CREDITS);
                tb_errors++;
            end
            withhold = 1'b0;
            host_oldest_idx = release_idx;
            hold_active = 1'b0;
            wait_credit(300, ok);
        end
        if (!ok)
        begin
            $display("timed out waiting for an input credit");
            tb_errors++;
        end
        else
        begin
            draw_bits(data_lfsr, 32, rnd);
            in_data = {lines_sent[31:0], rnd};
            in_valid = 1'b1;
            lines_sent++;
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    // Every line written, then a fence and a status write with the line count
    task automatic wait_drained();
        int t;
        t = 0;
        while (t < 600 && !(lines_written == lines_sent && !status_pending
                            && status_value == lines_sent[5:0]))
        begin
            @(negedge clk);
            t++;
        end
        if (t == 600)
        begin
            $display("timed out waiting for the fence and status write of %0d lines",
                     lines_sent);
            tb_errors++;
        end
    endtask

    initial
    begin
        reset_n = 1'b0;
        enable = 1'b0;
        ring_base = 32'h8000_1000;
        status_addr = 32'h0000_0f00;
        host_oldest_idx = '0;
        in_valid = 1'b0;
        in_data = '0;
        repeat (8) @(negedge clk);
        reset_n = 1'b1;
        enable = 1'b1;

        for (int r = 0; r < ROWS; r++)
        begin
            host_oldest_idx = row_oldest[r];
            release_idx = row_release[r];
            withhold = row_withhold[r];
            hold_active = row_withhold[r] || (row_oldest[r] != row_release[r]);
            for (int i = 0; i < row_burst[r]; i++)
            begin
                send_line();
            end
            if (hold_active)
            begin
                $display("row %0d never stalled the producer", r);
                tb_errors++;
            end
            withhold = 1'b0;
            host_oldest_idx = release_idx;
            hold_active = 1'b0;
            repeat (row_gap[r]) @(negedge clk);
            wait_drained();
        end

        if (credit_count != accepted_count)
        begin
            $display("[FAIL] in_credit count: got %h expected %h", credit_count, accepted_count);
            tb_errors++;
        end

        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/host_ring_pkg.sv ====
// Sizes, credit limits and FSM state codes for the host ring-buffer writer
// Host write kinds and the two-view request header union
package host_ring_pkg;

    // ====================
    // Data path and ring sizes
    // ====================
    localparam int LINE_BITS = 64;
    localparam int RING_IDX_BITS = 6;
    localparam int ADDR_BITS = 32;

    // Padding that widens a ring index to a full host address
    localparam int FENCE_PAD_BITS = ADDR_BITS - RING_IDX_BITS;

    // ====================
    // Credits and flush timing
    // ====================
    // Line FIFO depth, which is also the producer's starting credit count
    localparam int IN_CREDITS = 4;
    localparam int IN_PTR_BITS = $clog2(IN_CREDITS);
    localparam int IN_CNT_BITS = $clog2(IN_CREDITS + 1);

    localparam int MEM_CREDITS = 4;
    localparam int MEM_CNT_BITS = $clog2(MEM_CREDITS + 1);
    localparam logic [MEM_CNT_BITS-1:0] MEM_CREDIT_INIT = MEM_CNT_BITS'(MEM_CREDITS);

    // A run of this many idle cycles forces a fence
    localparam int IDLE_FLUSH_CYCLES = 16;
    localparam int IDLE_CNT_BITS = $clog2(IDLE_FLUSH_CYCLES + 1);
    localparam logic [IDLE_CNT_BITS-1:0] IDLE_LIMIT = IDLE_CNT_BITS'(IDLE_FLUSH_CYCLES);

    // Ring writer FSM state codes
    localparam int STATE_BITS = 2;
    localparam logic [STATE_BITS-1:0] ST_WAIT_EMPTY = 2'd0;
    localparam logic [STATE_BITS-1:0] ST_WAIT_DATA = 2'd1;
    localparam logic [STATE_BITS-1:0] ST_EMIT_FENCE = 2'd2;

    // Kind of a host write
    typedef enum logic [1:0]
    {
        KIND_LINE = 2'd0,
        KIND_FENCE = 2'd1,
        KIND_STATUS = 2'd2
    } req_kind_e;

    // One header word, read as an addressed write or as a fence
    // The kind sits in the top two bits of both views
    typedef union packed
    {
        struct packed
        {
            req_kind_e kind;
            logic [ADDR_BITS-1:0] addr;
        } wr;
        struct packed
        {
            req_kind_e kind;
            logic [RING_IDX_BITS-1:0] tag;
            logic [FENCE_PAD_BITS-1:0] pad;
        } fence;
    } req_hdr_u;

endpackage

// ==== verilog/host_ring_top.sv ====
// Top level of the host ring-buffer writer
// Line FIFO, ring writer, status writer and write arbiter
`timescale 1ns/1ps

module host_ring_top
(
    input  logic clk,
    input  logic reset_n,

    // Configuration
    input  logic enable,
    input  logic [host_ring_pkg::ADDR_BITS-1:0] ring_base,
    input  logic [host_ring_pkg::ADDR_BITS-1:0] status_addr,
    input  logic [host_ring_pkg::RING_IDX_BITS-1:0] host_oldest_idx,

    // Producer stream with returned input credits
    input  logic in_valid,
    input  logic [host_ring_pkg::LINE_BITS-1:0] in_data,
    output logic in_credit,

    // Host write channel with returned write credits
    output logic mem_valid,
    output host_ring_pkg::req_hdr_u mem_hdr,
    output logic [host_ring_pkg::LINE_BITS-1:0] mem_data,
    input  logic mem_credit
);

    // ====================
    // FIFO to ring writer
    // ====================
    logic [host_ring_pkg::LINE_BITS-1:0] fifo_line;
    logic fifo_nonempty;
    logic fifo_pop;

    // ====================
    // Requesters to arbiter
    // ====================
    logic ring_req;
    host_ring_pkg::req_hdr_u ring_hdr;
    logic [host_ring_pkg::LINE_BITS-1:0] ring_data;
    logic ring_grant;

    logic stat_req;
    host_ring_pkg::req_hdr_u stat_hdr;
    logic [host_ring_pkg::LINE_BITS-1:0] stat_data;
    logic stat_grant;

    // Fenced index from the ring writer to the status writer
    logic [host_ring_pkg::RING_IDX_BITS-1:0] published_idx;

    line_fifo i_line_fifo
    (
        .clk,
        .reset_n,
        .in_valid,
        .in_data,
        .in_credit,
        .fifo_pop,
        .fifo_line,
        .fifo_nonempty
    );

    ring_writer i_ring_writer
    (
        .clk,
        .reset_n,
        .enable,
        .ring_base,
        .host_oldest_idx,
        .fifo_line,
        .fifo_nonempty,
        .fifo_pop,
        .ring_req,
        .ring_hdr,
        .ring_data,
        .ring_grant,
        .published_idx
    );

    status_writer i_status_writer
    (
        .clk,
        .reset_n,
        .status_addr,
        .published_idx,
        .stat_req,
        .stat_hdr,
        .stat_data,
        .stat_grant
    );

    write_arbiter i_write_arbiter
    (
        .clk,
        .reset_n,
        .ring_req,
        .ring_hdr,
        .ring_data,
        .ring_grant,
        .stat_req,
        .stat_hdr,
        .stat_data,
        .stat_grant,
        .mem_valid,
        .mem_hdr,
        .mem_data,
        .mem_credit
    );

endmodule

// ==== verilog/line_fifo.sv ====
// Input line buffer for the producer stream
// Credited pushes in, one returned input credit per line handed on
`timescale 1ns/1ps

module line_fifo
(
    input  logic clk,
    input  logic reset_n,

    input  logic in_valid,
    input  logic [host_ring_pkg::LINE_BITS-1:0] in_data,
    output logic in_credit,

    input  logic fifo_pop,
    output logic [host_ring_pkg::LINE_BITS-1:0] fifo_line,
    output logic fifo_nonempty
);

    // Storage has no reset, only the pointers and the count do
    logic [host_ring_pkg::LINE_BITS-1:0] mem [host_ring_pkg::IN_CREDITS];

    logic [host_ring_pkg::IN_PTR_BITS-1:0] wr_ptr;
    logic [host_ring_pkg::IN_PTR_BITS-1:0] rd_ptr;
    logic [host_ring_pkg::IN_CNT_BITS-1:0] count;

    // The producer never pushes without a credit, so a push always finds room
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Depth is a power of two, so the pointers wrap on their own
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            in_credit <= 1'b0;
        end
        else
        begin
            if (in_valid)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({in_valid, fifo_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase

            // Each line handed on frees one slot and returns one credit
            in_credit <= fifo_pop;
        end
    end

    // A push shows up here one cycle later
    assign fifo_nonempty = (count != '0);
    assign fifo_line = mem[rd_ptr];

endmodule

// ==== verilog/ring_writer.sv ====
// Ring index tracking and line write requests to the host ring
// Fence FSM with quarter-ring and idle flush triggers
// Exports the fenced index that the status writer publishes
`timescale 1ns/1ps

module ring_writer
(
    input  logic clk,
    input  logic reset_n,

    input  logic enable,
    input  logic [host_ring_pkg::ADDR_BITS-1:0] ring_base,
    input  logic [host_ring_pkg::RING_IDX_BITS-1:0] host_oldest_idx,

    input  logic [host_ring_pkg::LINE_BITS-1:0] fifo_line,
    input  logic fifo_nonempty,
    output logic fifo_pop,

    output logic ring_req,
    output host_ring_pkg::req_hdr_u ring_hdr,
    output logic [host_ring_pkg::LINE_BITS-1:0] ring_data,
    input  logic ring_grant,

    output logic [host_ring_pkg::RING_IDX_BITS-1:0] published_idx
);

    // ====================
    // Ring pointers
    // ====================

    logic [host_ring_pkg::STATE_BITS-1:0] state;

    // Slot that the next line write goes to
    logic [host_ring_pkg::RING_IDX_BITS-1:0] cur_idx;
    logic [host_ring_pkg::RING_IDX_BITS-1:0] next_idx;
    logic [host_ring_pkg::ADDR_BITS-1:0] cur_idx_ext;

    assign next_idx = cur_idx + 1'b1;
    assign cur_idx_ext = {{host_ring_pkg::FENCE_PAD_BITS{1'b0}}, cur_idx};

    // Writing into the host's oldest live slot would overrun unread lines
    logic allow_write;
    assign allow_write = (next_idx != host_oldest_idx);

    // ====================
    // Flush triggers
    // ====================

    // The quarter bit flips each time the index crosses a quarter of the ring
    logic flush_for_writes;
    assign flush_for_writes =
        cur_idx[host_ring_pkg::RING_IDX_BITS-2] != published_idx[host_ring_pkg::RING_IDX_BITS-2];

    logic [host_ring_pkg::IDLE_CNT_BITS-1:0] idle_cnt;
    logic flush_for_idle;
    assign flush_for_idle = (idle_cnt == host_ring_pkg::IDLE_LIMIT);

    logic flush_now;
    assign flush_now = flush_for_writes || flush_for_idle;

    logic emit_fence;
    logic wait_data;
    assign emit_fence = (state == host_ring_pkg::ST_EMIT_FENCE);
    assign wait_data = (state == host_ring_pkg::ST_WAIT_DATA);

    // Lines are held back once a flush is due so the fence goes out first
    logic line_ready;
    assign line_ready = fifo_nonempty && !emit_fence && !(wait_data && flush_now);

    assign ring_req = enable && allow_write && (line_ready || emit_fence);

    // A request left waiting means the host channel is out of write credits
    logic stalled;
    assign stalled = ring_req && !ring_grant;

    // Any grant outside the fence state is a line write leaving the FIFO
    assign fifo_pop = ring_grant && !emit_fence;

    // Idle cycles count only while lines are pending and the channel isn't stalled
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            idle_cnt <= '0;
        end
        else if (!wait_data || fifo_pop)
        begin
            idle_cnt <= '0;
        end
        else if (!stalled && !flush_for_idle)
        begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    // ====================
    // Fence FSM
    // ====================
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= host_ring_pkg::ST_WAIT_EMPTY;
            cur_idx <= '0;
            published_idx <= '0;
        end
        else
        begin
            case (state)
                host_ring_pkg::ST_WAIT_EMPTY:
                begin
                    // First line since the last fence
                    if (ring_grant)
                    begin
                        state <= host_ring_pkg::ST_WAIT_DATA;
                        cur_idx <= next_idx;
                    end
                end

                host_ring_pkg::ST_WAIT_DATA:
                begin
                    if (ring_grant)
                    begin
                        cur_idx <= next_idx;
                    end
                    // The fence state holds the trigger until the fence is granted
                    if (flush_now)
                    begin
                        state <= host_ring_pkg::ST_EMIT_FENCE;
                    end
                end

                host_ring_pkg::ST_EMIT_FENCE:
                begin
                    // Everything below cur_idx is now committed
                    if (ring_grant)
                    begin
                        state <= host_ring_pkg::ST_WAIT_EMPTY;
                        published_idx <= cur_idx;
                    end
                end

                default:
                begin
                    state <= host_ring_pkg::ST_WAIT_EMPTY;
                end
            endcase
        end
    end

    // ====================
    // Request header
    // ====================
    always_comb
    begin
        ring_hdr = '0;
        if (emit_fence)
        begin
            // The fence tag carries the index being committed
            ring_hdr.fence.kind = host_ring_pkg::KIND_FENCE;
            ring_hdr.fence.tag = cur_idx;
        end
        else
        begin
            ring_hdr.wr.kind = host_ring_pkg::KIND_LINE;
            ring_hdr.wr.addr = ring_base + cur_idx_ext;
        end
    end

    assign ring_data = fifo_line;

endmodule

// ==== verilog/status_writer.sv ====
// Status word writer for the host
// Sends the fenced ring index to the status address when it changes
`timescale 1ns/1ps

module status_writer
(
    input  logic clk,
    input  logic reset_n,

    input  logic [host_ring_pkg::ADDR_BITS-1:0] status_addr,
    input  logic [host_ring_pkg::RING_IDX_BITS-1:0] published_idx,

    output logic stat_req,
    output host_ring_pkg::req_hdr_u stat_hdr,
    output logic [host_ring_pkg::LINE_BITS-1:0] stat_data,
    input  logic stat_grant
);

    // Registered copy of the published index
    // The request rises the cycle after the index moves
    logic [host_ring_pkg::RING_IDX_BITS-1:0] pub_q;

    // Last index that actually reached the host
    logic [host_ring_pkg::RING_IDX_BITS-1:0] sent_idx;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pub_q <= '0;
            sent_idx <= '0;
        end
        else
        begin
            pub_q <= published_idx;
            // pub_q always tracks the newest index, so a waiting request
            // picks up any later change before it is granted
            if (stat_grant)
            begin
                sent_idx <= pub_q;
            end
        end
    end

    assign stat_req = (pub_q != sent_idx);

    always_comb
    begin
        stat_hdr = '0;
        stat_hdr.wr.kind = host_ring_pkg::KIND_STATUS;
        stat_hdr.wr.addr = status_addr;
    end

    // The status word is the index, zero extended to a full line
    assign stat_data = {{(host_ring_pkg::LINE_BITS - host_ring_pkg::RING_IDX_BITS){1'b0}}, pub_q};

endmodule

// ==== verilog/write_arbiter.sv ====
// Round-robin merge of ring and status requests onto the host write channel
// Write credit counter and registered channel outputs
`timescale 1ns/1ps

module write_arbiter
(
    input  logic clk,
    input  logic reset_n,

    input  logic ring_req,
    input  host_ring_pkg::req_hdr_u ring_hdr,
    input  logic [host_ring_pkg::LINE_BITS-1:0] ring_data,
    output logic ring_grant,

    input  logic stat_req,
    input  host_ring_pkg::req_hdr_u stat_hdr,
    input  logic [host_ring_pkg::LINE_BITS-1:0] stat_data,
    output logic stat_grant,

    output logic mem_valid,
    output host_ring_pkg::req_hdr_u mem_hdr,
    output logic [host_ring_pkg::LINE_BITS-1:0] mem_data,
    input  logic mem_credit
);

    logic [host_ring_pkg::MEM_CNT_BITS-1:0] credits;
    logic has_credit;

    // Set when the status writer wins the next tie
    logic stat_first;

    assign has_credit = (credits != '0);

    // Grants are combinational, nothing is granted without a credit
    assign ring_grant = has_credit && ring_req && (!stat_req || !stat_first);
    assign stat_grant = has_credit && stat_req && (!ring_req || stat_first);

    logic any_grant;
    host_ring_pkg::req_hdr_u sel_hdr;
    logic [host_ring_pkg::LINE_BITS-1:0] sel_data;

    assign any_grant = ring_grant || stat_grant;
    assign sel_hdr = stat_grant ? stat_hdr : ring_hdr;
    assign sel_data = stat_grant ? stat_data : ring_data;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            credits <= host_ring_pkg::MEM_CREDIT_INIT;
            stat_first <= 1'b0;
            mem_valid <= 1'b0;
        end
        else
        begin
            // A grant spends a credit, a returned credit refills one
            case ({any_grant, mem_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase

            // The winner drops to low priority
            if (ring_grant)
            begin
                stat_first <= 1'b1;
            end
            else if (stat_grant)
            begin
                stat_first <= 1'b0;
            end

            mem_valid <= any_grant;
        end
    end

    // Fences carry no payload, so their data word goes out as zero
    always_ff @(posedge clk)
    begin
        if (any_grant)
        begin
            mem_hdr <= sel_hdr;
            if (sel_hdr.wr.kind == host_ring_pkg::KIND_FENCE)
            begin
                mem_data <= '0;
            end
            else
            begin
                mem_data <= sel_data;
            end
        end
    end

endmodule
